//--- src/hwpe_stream_consts.svh
/*
  Shared constants of the stream buffer.
  Strobe width is derived as data width / 8, so the data width must be a byte multiple.
  Register offsets are word offsets; the slave drops the two low byte address bits.
*/
`ifndef HWPE_STREAM_CONSTS_SVH
`define HWPE_STREAM_CONSTS_SVH

`define STREAM_DATA_WIDTH 32 // Bits per stream word
`define STREAM_FIFO_DEPTH 8  // Default FIFO depth, at least 2
`define WB_ADR_WIDTH      4  // Byte address bits seen by the slave

`define REG_DATA   0 // Push on write, pop on read
`define REG_STATUS 1 // FIFO flags, read only
`define REG_CLEAR  2 // Write pulses clear

`define FLAG_EMPTY        0
`define FLAG_FULL         1
`define FLAG_ALMOST_EMPTY 2
`define FLAG_ALMOST_FULL  3

`endif

//--- src/hwpe_stream_package.sv
/*
  Types shared by the stream buffer blocks.
  Widths come from the consts header; flags are a plain vector indexed by FLAG_* bits.
*/
`include "hwpe_stream_consts.svh"

package hwpe_stream_package;

  typedef logic [`STREAM_DATA_WIDTH-1:0]   stream_data_t; // One stream word
  typedef logic [`STREAM_DATA_WIDTH/8-1:0] stream_strb_t; // One enable per byte
  typedef logic [3:0]                      flags_fifo_t;  // Bit positions in FLAG_*
  typedef logic [`WB_ADR_WIDTH-1:0]        wb_adr_t;      // Byte address

  // FIFO fill state
  typedef enum logic [1:0] {
    EMPTY,
    MIDDLE,
    FULL
  } fifo_state_e;

  // Bus port state
  typedef enum logic [1:0] {
    IDLE,
    WAIT_PUSH,
    WAIT_POP,
    ACK
  } wb_state_e;

endpackage

//--- src/hwpe_stream_intf_stream.sv
/*
  Valid/ready stream carrying one word plus byte strobes.
  A beat moves on a rising edge with valid and ready both high.
  The source keeps data and strb stable while valid waits for ready.
*/
`timescale 1ns/1ns

interface hwpe_stream_intf_stream import hwpe_stream_package::*; ();

  logic         valid;
  logic         ready;
  stream_data_t data;
  stream_strb_t strb;

  modport source (
    output valid, data, strb,
    input  ready
  );

  modport sink (
    input  valid, data, strb,
    output ready
  );

  // Passive observer, e.g. for a checker
  modport monitor (
    input valid, ready, data, strb
  );

endinterface

//--- src/hwpe_stream_fifo.sv
/*
  Single-clock circular FIFO on stream interfaces, flip-flop storage only.
  No fall-through: a pushed beat shows at the pop side one cycle later at the earliest.
  FIFO_DEPTH must be 2 or more; it need not be a power of two.
  Flags come from registered state only. clear_i empties the FIFO and zeroes storage.
*/
`timescale 1ns/1ns
`include "hwpe_stream_consts.svh"

module hwpe_stream_fifo import hwpe_stream_package::*; #(
  parameter int unsigned FIFO_DEPTH = `STREAM_FIFO_DEPTH
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  output flags_fifo_t            flags_o,
  hwpe_stream_intf_stream.sink   push_i,
  hwpe_stream_intf_stream.source pop_o
);

  localparam int unsigned ADDR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  fifo_state_e state_q, state_d;

  logic [ADDR_W-1:0] push_ptr_q, push_ptr_d;
  logic [ADDR_W-1:0] pop_ptr_q, pop_ptr_d;
  logic [ADDR_W-1:0] push_ptr_nxt; // Wrapped successors
  logic [ADDR_W-1:0] pop_ptr_nxt;

  stream_data_t data_q [FIFO_DEPTH];
  stream_strb_t strb_q [FIFO_DEPTH];

  logic push_fire;
  logic pop_fire;

  // Increment with wrap at the last entry
  function automatic logic [ADDR_W-1:0] next_ptr(input logic [ADDR_W-1:0] ptr);
    if (ptr == ADDR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push_ptr_nxt = next_ptr(push_ptr_q);
  assign pop_ptr_nxt  = next_ptr(pop_ptr_q);

  // Handshakes, both gated by own state
  assign push_i.ready = (state_q != FULL);
  assign pop_o.valid  = (state_q != EMPTY);
  assign push_fire    = push_i.valid & push_i.ready;
  assign pop_fire     = pop_o.valid & pop_o.ready;

  // Read port, straight from storage
  assign pop_o.data = data_q[pop_ptr_q];
  assign pop_o.strb = strb_q[pop_ptr_q];

  always_comb begin
    flags_o                     = '0;
    flags_o[`FLAG_EMPTY]        = (state_q == EMPTY);
    flags_o[`FLAG_FULL]         = (state_q == FULL);
    // One entry held
    flags_o[`FLAG_ALMOST_EMPTY] = (state_q == MIDDLE) && (pop_ptr_nxt == push_ptr_q);
    // One slot free
    flags_o[`FLAG_ALMOST_FULL]  = (state_q == MIDDLE) && (push_ptr_nxt == pop_ptr_q);
  end

  // Pointers only move on a transfer
  assign push_ptr_d = push_fire ? push_ptr_nxt : push_ptr_q;
  assign pop_ptr_d  = pop_fire  ? pop_ptr_nxt  : pop_ptr_q;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      EMPTY: begin
        if (push_fire) begin
          state_d = MIDDLE;
        end
      end
      MIDDLE: begin
        case ({push_fire, pop_fire})
          2'b10: begin
            if (push_ptr_nxt == pop_ptr_q) begin // Last free slot taken
              state_d = FULL;
            end
          end
          2'b01: begin
            if (pop_ptr_nxt == push_ptr_q) begin // Last entry leaves
              state_d = EMPTY;
            end
          end
          default: begin
            state_d = MIDDLE; // Idle or push and pop together
          end
        endcase
      end
      FULL: begin
        if (pop_fire) begin
          state_d = MIDDLE;
        end
      end
      default: begin
        state_d = EMPTY;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= EMPTY;
      push_ptr_q <= '0;
      pop_ptr_q  <= '0;
    end else if (clear_i) begin
      state_q    <= EMPTY;
      push_ptr_q <= '0;
      pop_ptr_q  <= '0;
    end else begin
      state_q    <= state_d;
      push_ptr_q <= push_ptr_d;
      pop_ptr_q  <= pop_ptr_d;
    end
  end

  // Storage, written at the push pointer
  always_ff @(posedge clk_i) begin
    if (clear_i) begin
      for (int i = 0; i < FIFO_DEPTH; i++) begin
        data_q[i] <= '0;
        strb_q[i] <= '0;
      end
    end else if (push_fire) begin
      data_q[push_ptr_q] <= push_i.data;
      strb_q[push_ptr_q] <= push_i.strb;
    end
  end

endmodule

//--- src/hwpe_stream_strb_mask.sv
/*
  One-entry elastic register stage.
  Bytes with a clear strobe leave as zero; outgoing strobes are all ones.
  Accepts when empty or when its output moves in the same cycle. clear_i drops the beat.
*/
`timescale 1ns/1ns

module hwpe_stream_strb_mask import hwpe_stream_package::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  hwpe_stream_intf_stream.sink   push_i,
  hwpe_stream_intf_stream.source pop_o
);

  logic         valid_q;
  stream_data_t data_q;
  stream_data_t masked;
  logic         push_fire;
  logic         pop_fire;

  // Zero every disabled byte
  always_comb begin
    masked = push_i.data;
    for (int b = 0; b < $bits(stream_strb_t); b++) begin
      if (!push_i.strb[b]) begin
        masked[8*b +: 8] = 8'h00;
      end
    end
  end

  assign push_i.ready = ~valid_q | pop_o.ready; // Free now or freed this cycle
  assign push_fire    = push_i.valid & push_i.ready;
  assign pop_fire     = valid_q & pop_o.ready;

  assign pop_o.valid = valid_q;
  assign pop_o.data  = data_q;
  assign pop_o.strb  = '1;                      // Every byte now meaningful

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (clear_i) begin
      valid_q <= 1'b0;
    end else if (push_fire) begin
      valid_q <= 1'b1;                          // Refill, possibly while draining
    end else if (pop_fire) begin
      valid_q <= 1'b0;
    end
  end

  // Payload, held under back-pressure
  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      data_q <= masked;
    end
  end

endmodule

//--- src/hwpe_stream_wb_port.sv
/*
  Wishbone classic slave in front of the stream path. No pipelined mode, no err/rty.
  Data writes stall in WAIT_PUSH until the FIFO accepts; data reads stall in WAIT_POP
  until a word arrives, so reading an empty buffer blocks the bus.
  Ack is one cycle wide; the host must drop stb after ack.
*/
`timescale 1ns/1ns
`include "hwpe_stream_consts.svh"

module hwpe_stream_wb_port import hwpe_stream_package::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  wb_adr_t                wb_adr_i,
  input  stream_data_t           wb_dat_i,
  input  stream_strb_t           wb_sel_i,
  output stream_data_t           wb_dat_o,
  output logic                   wb_ack_o,
  input  flags_fifo_t            flags_i,
  output logic                   clear_o,
  hwpe_stream_intf_stream.source push_o,
  hwpe_stream_intf_stream.sink   pop_i
);

  localparam int unsigned OFF_W = `WB_ADR_WIDTH - 2;

  localparam logic [OFF_W-1:0] OFF_DATA   = `REG_DATA;
  localparam logic [OFF_W-1:0] OFF_STATUS = `REG_STATUS;
  localparam logic [OFF_W-1:0] OFF_CLEAR  = `REG_CLEAR;

  wb_state_e        state_q, state_d;
  logic [OFF_W-1:0] word_off;
  logic             req;
  logic             clear_q;
  stream_data_t     rdata_q;

  assign word_off = wb_adr_i[`WB_ADR_WIDTH-1:2]; // Byte to word address
  assign req      = wb_cyc_i & wb_stb_i;

  // Stream side, host holds dat and sel for the whole cycle
  assign push_o.valid = (state_q == WAIT_PUSH);
  assign push_o.data  = wb_dat_i;
  assign push_o.strb  = wb_sel_i;
  assign pop_i.ready  = (state_q == WAIT_POP);

  assign wb_ack_o = (state_q == ACK);
  assign wb_dat_o = rdata_q;
  assign clear_o  = clear_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req) begin
          if (word_off == OFF_DATA) begin
            state_d = wb_we_i ? WAIT_PUSH : WAIT_POP;
          end else begin
            state_d = ACK; // Status, clear and unmapped
          end
        end
      end
      WAIT_PUSH: if (push_o.ready) state_d = ACK;
      WAIT_POP:  if (pop_i.valid)  state_d = ACK;
      default:   state_d = IDLE;   // ACK lasts one cycle
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      clear_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Single pulse, lines up with ack
      clear_q <= (state_q == IDLE) && req && wb_we_i && (word_off == OFF_CLEAR);
    end
  end

  // Read data, captured when the access resolves
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req) begin
      if (!wb_we_i && word_off == OFF_STATUS) begin
        rdata_q <= stream_data_t'(flags_i); // Flags in low bits
      end else begin
        rdata_q <= '0;
      end
    end else if (state_q == WAIT_POP && pop_i.valid) begin
      rdata_q <= pop_i.data;
    end
  end

endmodule

//--- src/hwpe_stream_buffer_top.sv
/*
  Stream buffer reachable over Wishbone classic.
  Path is port -> FIFO -> strobe mask -> port. Up to FIFO_DEPTH words sit in the FIFO,
  one more in the mask stage. Register map in the consts header.
*/
`timescale 1ns/1ns
`include "hwpe_stream_consts.svh"

module hwpe_stream_buffer_top import hwpe_stream_package::*; #(
  parameter int unsigned FIFO_DEPTH = `STREAM_FIFO_DEPTH
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         wb_cyc_i,
  input  logic         wb_stb_i,
  input  logic         wb_we_i,
  input  wb_adr_t      wb_adr_i,
  input  stream_data_t wb_dat_i,
  input  stream_strb_t wb_sel_i,
  output stream_data_t wb_dat_o,
  output logic         wb_ack_o
);

  flags_fifo_t flags;
  logic        clear;

  hwpe_stream_intf_stream wb_push ();  // Port to FIFO
  hwpe_stream_intf_stream fifo_pop (); // FIFO to mask stage
  hwpe_stream_intf_stream mask_pop (); // Mask stage back to port

  hwpe_stream_wb_port i_wb_port (
    .clk_i    ( clk_i    ),
    .rst_ni   ( rst_ni   ),
    .wb_cyc_i ( wb_cyc_i ),
    .wb_stb_i ( wb_stb_i ),
    .wb_we_i  ( wb_we_i  ),
    .wb_adr_i ( wb_adr_i ),
    .wb_dat_i ( wb_dat_i ),
    .wb_sel_i ( wb_sel_i ),
    .wb_dat_o ( wb_dat_o ),
    .wb_ack_o ( wb_ack_o ),
    .flags_i  ( flags    ),
    .clear_o  ( clear    ),
    .push_o   ( wb_push  ),
    .pop_i    ( mask_pop )
  );

  hwpe_stream_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_fifo (
    .clk_i   ( clk_i    ),
    .rst_ni  ( rst_ni   ),
    .clear_i ( clear    ),
    .flags_o ( flags    ),
    .push_i  ( wb_push  ),
    .pop_o   ( fifo_pop )
  );

  hwpe_stream_strb_mask i_strb_mask (
    .clk_i   ( clk_i    ),
    .rst_ni  ( rst_ni   ),
    .clear_i ( clear    ),
    .push_i  ( fifo_pop ),
    .pop_o   ( mask_pop )
  );

endmodule

//--- test/tb_stream_buffer.sv
/*
  Self-checking testbench for the Wishbone stream buffer, default FIFO depth.
  One host, one access at a time. A read of an empty buffer stalls the bus,
  so every read follows a matching write.
  Buffer holds FIFO depth + 1 words (FIFO plus mask stage); bursts stay within that.
*/
`timescale 1ns/1ns
`include "hwpe_stream_consts.svh"

module tb_stream_buffer import hwpe_stream_package::*; ();

  localparam int CLK_PERIOD    = 4;
  localparam int DEPTH         = `STREAM_FIFO_DEPTH;
  localparam int ACCESS_BUDGET = 250; // Upper bound on bus accesses over all tests
  localparam int ACCESS_CYCLES = 20;  // Generous cycles per access
  localparam int WATCHDOG_NS   = ACCESS_BUDGET * ACCESS_CYCLES * CLK_PERIOD;
  localparam int ACK_LIMIT     = 100; // Cycles before one access counts as stuck

  logic         clk_i = 1'b0;
  logic         rst_ni;
  logic         wb_cyc_i;
  logic         wb_stb_i;
  logic         wb_we_i;
  wb_adr_t      wb_adr_i;
  stream_data_t wb_dat_i;
  stream_strb_t wb_sel_i;
  stream_data_t wb_dat_o;
  logic         wb_ack_o;

  stream_data_t model_q [$];        // Masked words, oldest first
  int           errors = 0;
  integer       seed   = 32'h19df7bde;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  hwpe_stream_buffer_top UUT (
    .clk_i    ( clk_i    ),
    .rst_ni   ( rst_ni   ),
    .wb_cyc_i ( wb_cyc_i ),
    .wb_stb_i ( wb_stb_i ),
    .wb_we_i  ( wb_we_i  ),
    .wb_adr_i ( wb_adr_i ),
    .wb_dat_i ( wb_dat_i ),
    .wb_sel_i ( wb_sel_i ),
    .wb_dat_o ( wb_dat_o ),
    .wb_ack_o ( wb_ack_o )
  );

  // Expected word: bytes with a clear strobe read as zero
  function automatic stream_data_t mask_word(input stream_data_t data, input stream_strb_t strb);
    stream_data_t keep;
    keep = '0;
    for (int b = 0; b < $bits(stream_strb_t); b++) begin
      keep[8*b +: 8] = {8{strb[b]}};
    end
    return data & keep;
  endfunction

  // Words in the FIFO alone, the stage holds the oldest one
  function automatic int fifo_level();
    return (model_q.size() > 0) ? model_q.size() - 1 : 0;
  endfunction

  function automatic flags_fifo_t expected_flags(input int level);
    flags_fifo_t f;
    f = '0;
    f[`FLAG_EMPTY]        = (level == 0);
    f[`FLAG_FULL]         = (level == DEPTH);
    f[`FLAG_ALMOST_EMPTY] = (level == 1);
    f[`FLAG_ALMOST_FULL]  = (level == DEPTH - 1);
    return f;
  endfunction

  task automatic compare_data(input string name, input stream_data_t exp, input stream_data_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic compare_flags(input string name, input flags_fifo_t exp, input flags_fifo_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s: expected flags %b, actual flags %b", name, exp, act);
    end
  endtask

  task automatic settle(input int cycles);
    repeat (cycles) @(posedge clk_i);
  endtask

  // Ack sampled at the falling edge, away from the DUT's updates
  task automatic wait_ack(input string what);
    logic acked;
    int   cycles;
    acked  = 1'b0;
    cycles = 0;
    while (!acked && cycles < ACK_LIMIT) begin
      @(negedge clk_i);
      acked = wb_ack_o;
      cycles++;
    end
    if (!acked) begin
      errors++;
      $display("ERROR: %s got no ack within %0d cycles", what, ACK_LIMIT);
    end
  endtask

  task automatic release_bus();
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic write_reg(input int off, input stream_data_t dat, input stream_strb_t sel);
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b1;
    wb_adr_i <= wb_adr_t'(off * 4); // Word offset to byte address
    wb_dat_i <= dat;
    wb_sel_i <= sel;
    wait_ack("bus write");
    release_bus();
  endtask

  task automatic read_reg(input int off, output stream_data_t dat);
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b0;
    wb_adr_i <= wb_adr_t'(off * 4);
    wait_ack("bus read");
    dat = wb_dat_o;                 // Valid while ack is high
    release_bus();
  endtask

  task automatic push_word(input stream_data_t dat, input stream_strb_t sel);
    write_reg(`REG_DATA, dat, sel);
    model_q.push_back(mask_word(dat, sel));
  endtask

  task automatic pop_check(input string name);
    stream_data_t act;
    stream_data_t exp;
    exp = model_q.pop_front();
    read_reg(`REG_DATA, act);
    compare_data(name, exp, act);
  endtask

  task automatic drain(input string name);
    while (model_q.size() > 0) begin
      pop_check(name);
    end
  endtask

  // Flags in the low bits, zero above
  task automatic check_status(input string name);
    stream_data_t act;
    settle(3); // Let the mask stage pull from the FIFO
    read_reg(`REG_STATUS, act);
    compare_flags(name, expected_flags(fifo_level()), flags_fifo_t'(act));
    compare_data({name, "_high_bits"}, '0, act >> $bits(flags_fifo_t));
  endtask

  task automatic burst(input string name, input int n, input logic rand_strb);
    stream_data_t d;
    stream_strb_t s;
    for (int i = 0; i < n; i++) begin
      d = $random(seed);
      s = rand_strb ? stream_strb_t'($random(seed)) : '1;
      push_word(d, s);
    end
    drain(name);
  endtask

  initial begin
    stream_data_t rd;
    rst_ni   <= 1'b0;
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    wb_adr_i <= '0;
    wb_dat_i <= '0;
    wb_sel_i <= '0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    check_status("t1_reset_status");
    read_reg(3, rd);                        // Unmapped offset
    compare_data("t1_unmapped_read", '0, rd);

    burst("t2_full_strobes", 5, 1'b0);
    burst("t2_full_strobes", 5, 1'b0);

    burst("t3_random_strobes", DEPTH, 1'b1);

    // Fill FIFO and stage completely, no reads in between
    for (int i = 0; i <= DEPTH; i++) begin
      push_word($random(seed), '1);
    end
    check_status("t4_full");
    drain("t4_drain_order");
    check_status("t4_drained");

    push_word($random(seed), '1);
    push_word($random(seed), '1);           // One in stage, one in FIFO
    check_status("t5_almost_empty");
    while (model_q.size() < DEPTH) begin
      push_word($random(seed), '1);
    end
    check_status("t5_almost_full");
    drain("t5_drain_order");

    for (int i = 0; i < 3; i++) begin
      push_word($random(seed), '1);
    end
    write_reg(`REG_CLEAR, '0, '1);
    model_q.delete();
    check_status("t6_after_clear");
    burst("t6_fresh_order", 4, 1'b1);
    check_status("t6_final");

    settle(2);
    $display("Closing: %0d errors", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog, budget derived from the access count
  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: run timed out after %0d ns, a bus access never finished", WATCHDOG_NS);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- stream_buffer.f
+incdir+src
src/hwpe_stream_package.sv
src/hwpe_stream_intf_stream.sv
src/hwpe_stream_fifo.sv
src/hwpe_stream_strb_mask.sv
src/hwpe_stream_wb_port.sv
src/hwpe_stream_buffer_top.sv
test/tb_stream_buffer.sv

//--- Makefile
# Verilator build and run of the stream buffer testbench
# Override any variable on the command line, e.g. make run LOG=out.log

VERILATOR ?= verilator
TOP       ?= tb_stream_buffer
FILELIST  ?= stream_buffer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
FAIL_MSG  ?= FAIL: see errors above
PASS_MSG  ?= PASS: all tests

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(FILELIST) $(wildcard src/*.sv src/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) $(VFLAGS)

run: compile
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
